/* list.f */
hw/cache_cfg_pkg.sv
hw/cache_ctrl_pkg.sv
hw/tag_memory_fa.sv
hw/cache_data_mem.sv
hw/cache_controller_fa.sv
hw/cache_perf_counter.sv
hw/cache_fa_all.sv
tb/cache_fa_chk.sv
tb/tb_cache_fa.sv

/* tb/tb_cache_fa.sv */
`default_nettype none

module tb_cache_fa;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CAP            = 4;	// blocks in the DUT
	localparam int TIMEOUT_CYCLES = 12000;	// 200 requests, 60 cycles worst case
	localparam logic [31:0] SEED  = 32'h4376a119;

	logic        clock_i, rst_n_i;
	logic [31:0] comm_i, comm_o;
	cache_ctrl_pkg::metric_t metric_sel_i;
	logic        core_req_i, core_rw_i, core_done_o, core_hit_o;
	logic [15:0] core_add_i, add_o;
	logic [31:0] core_data_i, core_data_o, data_i, data_o;
	logic        en_i, ready_req_i, ready_write_i, ready_read_i;
	logic        req_o, req_block_o, rw_o, write_o, read_o;

	logic [31:0] backing [65536];	// buffer side memory
	logic [31:0] ref_mem [65536];	// what the core should see
	logic [13:0] line_tag [CAP];	// cache model, round-robin
	logic        line_valid [CAP];
	logic        line_dirty [CAP];
	int          rr_way = 0, n_req = 0, n_hit = 0, n_miss = 0, n_wb = 0;
	int          n_checks = 0, n_errors = 0, fill_cmds = 0, wb_cmds = 0, cycle_cnt = 0;
	logic        counting, stall_en;
	logic [15:0] xfer_base, last_fill_add, last_wb_add;
	logic [1:0]  xfer_cnt;	// beat inside the current block
	logic [31:0] stim_rnd, rdy_rnd;

	cache_fa_all #(.CACHE_BLOCK_CAPACITY(CAP)) u_dut (.*);

	bind cache_fa_all cache_fa_chk u_chk (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .core_done_o(core_done_o),
		.core_hit_o(core_hit_o), .req_o(req_o), .rw_o(rw_o), .add_o(add_o),
		.ready_req_i(ready_req_i), .write_o(write_o), .ready_write_i(ready_write_i),
		.read_o(read_o), .ready_read_i(ready_read_i),
		.flag_req_i(flag_req), .cam_hit_i(cam_hit)
	);

	initial begin
		clock_i = 1'b0;
		forever #20 clock_i = ~clock_i;
	end

	always @(posedge clock_i) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, a request never completed", cycle_cnt);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] init_word(input logic [15:0] a);
		return {a ^ 16'h9e37, ~a};	// every address bit shows up
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
	                           input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// --------------------------------------------------
	// buffer model, driven on the falling edge
	// --------------------------------------------------
	always @(negedge clock_i) begin
		rdy_rnd = lcg_step(rdy_rnd);
		ready_req_i   = !stall_en || (|rdy_rnd[17:16]);	// 3 of 4 when stalling
		ready_write_i = !stall_en || (|rdy_rnd[20:19]);
		ready_read_i  = !stall_en || (|rdy_rnd[23:22]);
		data_i = backing[xfer_base + {14'd0, xfer_cnt}];	// word for the next read beat
		#1;	// strobes now show what the next rising edge does
		if (req_o && ready_req_i) begin	// command taken at the next rising edge
			check_value("block request flag", 32'(req_block_o), 32'd1);
			xfer_base = add_o;
			xfer_cnt  = 2'd0;
			if (rw_o) begin
				wb_cmds++;
				last_wb_add = add_o;
			end else begin
				fill_cmds++;
				last_fill_add = add_o;
			end
		end
		if (write_o) begin
			backing[xfer_base + {14'd0, xfer_cnt}] = data_o;
			xfer_cnt++;
		end
		if (read_o)
			xfer_cnt++;	// current data_i consumed
	end

	// one core request, expected outcome from the round-robin model
	task automatic do_request(input logic rw, input logic [15:0] addr,
	                          input logic [31:0] wdata);
		int          way;
		int          fills0;
		int          wbs0;
		logic        exp_hit;
		logic        exp_wb;
		logic [15:0] victim;
		logic [31:0] exp_data;
		way    = -1;
		exp_wb = 1'b0;
		victim = '0;
		for (int i = 0; i < CAP; i++)
			if (line_valid[i] && line_tag[i] == addr[15:2])
				way = i;
		exp_hit = (way >= 0);
		if (!exp_hit) begin	// victim is the round-robin way
			exp_wb             = line_dirty[rr_way];
			victim             = {line_tag[rr_way], 2'b00};
			line_tag[rr_way]   = addr[15:2];
			line_valid[rr_way] = 1'b1;
			line_dirty[rr_way] = 1'b0;
			way                = rr_way;
			rr_way             = (rr_way + 1) % CAP;
		end
		exp_data = ref_mem[addr];
		if (rw) begin
			line_dirty[way] = 1'b1;
			ref_mem[addr]   = wdata;
		end
		if (counting) begin
			n_req++;
			n_hit  += exp_hit;
			n_miss += !exp_hit;
			n_wb   += exp_wb;
		end
		fills0      = fill_cmds;
		wbs0        = wb_cmds;
		core_rw_i   = rw;
		core_add_i  = addr;
		core_data_i = wdata;
		core_req_i  = 1'b1;	// held until done
		@(negedge clock_i);
		while (!core_done_o)
			@(negedge clock_i);
		core_req_i = 1'b0;
		check_value("hit flag", 32'(core_hit_o), 32'(exp_hit));
		if (!rw)
			check_value("read data", core_data_o, exp_data);
		check_value("fill commands", fill_cmds - fills0, exp_hit ? 0 : 1);
		check_value("writeback commands", wb_cmds - wbs0, 32'(exp_wb));
		if (!exp_hit)
			check_value("fill address", 32'(last_fill_add), {16'd0, addr[15:2], 2'b00});
		if (exp_wb) begin
			check_value("writeback address", 32'(last_wb_add), 32'(victim));
			for (int k = 0; k < 4; k++)	// block landed word by word in order
				check_value("written back word", backing[victim + 16'(k)],
				            ref_mem[victim + 16'(k)]);
		end
	endtask

	task automatic check_counter(input cache_ctrl_pkg::metric_t m, input int exp,
	                             input string what);
		metric_sel_i = m;
		@(negedge clock_i);	// comm_o registered one cycle later
		check_value(what, comm_o, exp);
	endtask

	task automatic check_all_counters();
		check_counter(cache_ctrl_pkg::MET_REQ, n_req, "request counter");
		check_counter(cache_ctrl_pkg::MET_HIT, n_hit, "hit counter");
		check_counter(cache_ctrl_pkg::MET_MISS, n_miss, "miss counter");
		check_counter(cache_ctrl_pkg::MET_WB, n_wb, "writeback counter");
	endtask

	task automatic send_comm(input cache_ctrl_pkg::comm_op_t op);
		comm_i = {24'd0, op};
		@(negedge clock_i);
		comm_i = {24'd0, cache_ctrl_pkg::COMM_NOP};
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		logic [15:0] addr;
		logic        done_seen;
		rst_n_i = 1'b0;
		comm_i = '0;
		metric_sel_i = cache_ctrl_pkg::MET_REQ;
		{core_req_i, core_rw_i, core_add_i, core_data_i} = '0;
		{en_i, ready_req_i, ready_write_i, ready_read_i} = 4'b1111;
		data_i = '0;
		{stall_en, counting} = 2'b01;
		{xfer_base, xfer_cnt, last_fill_add, last_wb_add} = '0;
		stim_rnd = SEED;
		rdy_rnd  = SEED;
		for (int a = 0; a < 65536; a++) begin
			backing[a] = init_word(16'(a));
			ref_mem[a] = init_word(16'(a));
		end
		for (int i = 0; i < CAP; i++)
			{line_tag[i], line_valid[i], line_dirty[i]} = '0;
		repeat (4) @(negedge clock_i);
		rst_n_i = 1'b1;
		@(negedge clock_i);

		do_request(1'b0, 16'h0100, '0);	// cold miss
		do_request(1'b0, 16'h0102, '0);	// same block hits
		stim_rnd = lcg_step(stim_rnd);
		do_request(1'b1, 16'h0101, stim_rnd);	// write hit, line goes dirty
		do_request(1'b0, 16'h0101, '0);
		do_request(1'b0, 16'h0200, '0);	// fill the rest of the ways
		do_request(1'b0, 16'h0300, '0);
		do_request(1'b0, 16'h0400, '0);
		do_request(1'b0, 16'h0500, '0);	// evicts dirty 0x0100
		do_request(1'b0, 16'h0101, '0);	// written word comes back from memory

		// random mix under back-pressure, 8 blocks over 4 ways
		stall_en = 1'b1;
		for (int n = 0; n < 150; n++) begin
			stim_rnd = lcg_step(stim_rnd);
			addr     = 16'h1000 | {11'd0, stim_rnd[20:16]};
			stim_rnd = lcg_step(stim_rnd);
			do_request(stim_rnd[27], addr, stim_rnd);
		end

		// request held with the cache disabled
		en_i = 1'b0;
		{core_req_i, core_rw_i, core_add_i} = {1'b1, 1'b0, 16'h1004};
		done_seen = 1'b0;
		repeat (10) begin
			@(negedge clock_i);
			done_seen |= core_done_o;
		end
		check_value("done with en_i low", 32'(done_seen), 0);
		en_i = 1'b1;
		do_request(1'b0, 16'h1004, '0);
		stall_en = 1'b0;

		check_all_counters();
		send_comm(cache_ctrl_pkg::COMM_CLEAR);
		n_req  = 0;
		n_hit  = 0;
		n_miss = 0;
		n_wb   = 0;
		check_all_counters();
		send_comm(cache_ctrl_pkg::COMM_HOLD);
		counting = 1'b0;	// frozen counters stay at zero
		do_request(1'b0, 16'h2000, '0);
		do_request(1'b1, 16'h2001, 32'h1234_5678);
		check_all_counters();
		send_comm(cache_ctrl_pkg::COMM_RUN);
		counting = 1'b1;
		for (int n = 0; n < 6; n++)
			do_request(1'b0, 16'h0500 + 16'(n * 256), '0);
		check_all_counters();

		$display("checks %0d, value errors %0d, assertion failures %0d",
		         n_checks, n_errors, u_dut.u_chk.fired);
		if (n_errors == 0 && u_dut.u_chk.fired == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/cache_fa_chk.sv */
`default_nettype none

// handshake and timing rules of cache_fa_all, bound into the DUT
module cache_fa_chk (
	input wire        clock_i,
	input wire        rst_n_i,
	input wire        core_done_o,
	input wire        core_hit_o,
	input wire        req_o,
	input wire        rw_o,
	input wire [15:0] add_o,
	input wire        ready_req_i,
	input wire        write_o,
	input wire        ready_write_i,
	input wire        read_o,
	input wire        ready_read_i,
	input wire        flag_req_i,	// request accepted in idle
	input wire        cam_hit_i	// lookup result
);
	timeunit 1ns;
	timeprecision 100ps;

	int fired = 0;	// failed assertions, read by the testbench

	// --------------------------------------------------
	// core side
	// --------------------------------------------------
	done_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		core_done_o |=> !core_done_o)
		else begin
			$error("core_done_o held longer than one cycle");
			fired++;
		end

	// idle -> lookup -> done, nothing in between on a hit
	hit_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		flag_req_i ##1 cam_hit_i |=> core_done_o && core_hit_o)
		else begin
			$error("hit did not finish two cycles after the request");
			fired++;
		end

	// --------------------------------------------------
	// buffer side
	// --------------------------------------------------
	write_ready: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		write_o |-> ready_write_i)
		else begin
			$error("write strobe without ready_write_i");
			fired++;
		end

	read_ready: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		read_o |-> ready_read_i)
		else begin
			$error("read strobe without ready_read_i");
			fired++;
		end

	// command held until the buffer takes it
	req_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req_o && !ready_req_i |=> req_o && $stable(rw_o) && $stable(add_o))
		else begin
			$error("req_o dropped or changed before ready_req_i");
			fired++;
		end

endmodule

`default_nettype wire

/* hw/cache_fa_all.sv */
`default_nettype none

module cache_fa_all #(
	parameter int CACHE_BLOCK_CAPACITY = 8,	// power of two, at least 2
	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY),
	localparam int BW_MEM = BW_IDX + cache_cfg_pkg::BW_BLOCK
) (
	// system
	input  wire                                    clock_i,
	input  wire                                    rst_n_i,
	input  wire [31:0]                             comm_i,	// perf command
	input  wire cache_ctrl_pkg::metric_t           metric_sel_i,
	output logic [31:0]                            comm_o,	// selected counter

	// core
	input  wire                                    core_req_i,	// held until done
	input  wire                                    core_rw_i,	// 1 write, 0 read
	input  wire [cache_cfg_pkg::BW_WORD_ADDR-1:0]  core_add_i,
	input  wire [cache_cfg_pkg::BW_DATA-1:0]       core_data_i,
	output logic                                   core_done_o,	// one-cycle pulse
	output logic                                   core_hit_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]      core_data_o,

	// buffer
	input  wire                                    en_i,
	input  wire                                    ready_req_i,	// buffer takes a command
	input  wire                                    ready_write_i,	// buffer takes a word
	input  wire                                    ready_read_i,	// buffer has a word
	input  wire [cache_cfg_pkg::BW_DATA-1:0]       data_i,
	output logic                                   req_o,
	output logic                                   req_block_o,
	output logic                                   rw_o,
	output logic                                   write_o,
	output logic                                   read_o,
	output logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] add_o,	// block base address
	output logic [cache_cfg_pkg::BW_DATA-1:0]      data_o
);

	// --------------------------------------------------
	// request split
	// --------------------------------------------------
	logic [cache_cfg_pkg::BW_TAG-1:0]   req_tag;
	logic [cache_cfg_pkg::BW_BLOCK-1:0] req_word;

	assign req_tag  = core_add_i[cache_cfg_pkg::BW_WORD_ADDR-1:cache_cfg_pkg::BW_BLOCK];
	assign req_word = core_add_i[cache_cfg_pkg::BW_BLOCK-1:0];

	logic                              cam_wren, cam_hit;
	logic [BW_IDX-1:0]                 cam_addr;	// controller to tag store
	logic [BW_IDX-1:0]                 cam_index;	// matching block
	logic [cache_cfg_pkg::BW_TAG-1:0]  cam_tag;	// victim tag
	logic [BW_MEM-1:0]                 mem_addr;
	logic                              mem_wren;
	logic [cache_cfg_pkg::BW_DATA-1:0] mem_wdata, mem_q;
	logic                              flag_req, flag_hit, flag_miss, flag_wb;

	// --------------------------------------------------
	// tag lookup
	// --------------------------------------------------
	tag_memory_fa #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_tag (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.wren_i  (cam_wren),
		.tag_i   (req_tag),	// new tag is always the requested one
		.add_i   (cam_addr),
		.add_o   (cam_index),
		.tag_o   (cam_tag),
		.hit_o   (cam_hit)
	);

	// --------------------------------------------------
	// block storage
	// --------------------------------------------------
	cache_data_mem #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_mem (
		.clock_i (clock_i),
		.wren_i  (mem_wren),
		.addr_i  (mem_addr),
		.data_i  (mem_wdata),
		.q_o     (mem_q)
	);

	assign core_data_o = mem_q;	// read word sits on q during the done cycle

	// --------------------------------------------------
	// controller
	// --------------------------------------------------
	cache_controller_fa #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_ctrl (
		.clock_i              (clock_i),
		.rst_n_i              (rst_n_i),
		.enable_i             (en_i),
		.core_req_i           (core_req_i),
		.core_rw_i            (core_rw_i),
		.core_tag_i           (req_tag),
		.core_word_i          (req_word),
		.core_data_i          (core_data_i),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.cam_hit_i            (cam_hit),
		.cam_addr_i           (cam_index),
		.cam_tag_i            (cam_tag),
		.cam_wren_o           (cam_wren),
		.cam_addr_o           (cam_addr),
		.mem_q_i              (mem_q),
		.mem_addr_o           (mem_addr),
		.mem_wren_o           (mem_wren),
		.mem_data_o           (mem_wdata),
		.buffer_read_ready_i  (ready_read_i),
		.buffer_data_i        (data_i),
		.buffer_read_ack_o    (read_o),
		.buffer_write_ready_i (ready_write_i),
		.buffer_data_o        (data_o),
		.buffer_write_ack_o   (write_o),
		.mem_ready_i          (ready_req_i),
		.mem_req_o            (req_o),
		.mem_req_block_o      (req_block_o),
		.mem_rw_o             (rw_o),
		.mem_req_add_o        (add_o),
		.flag_req_o           (flag_req),
		.flag_hit_o           (flag_hit),
		.flag_miss_o          (flag_miss),
		.flag_wb_o            (flag_wb)
	);

	// --------------------------------------------------
	// performance counters
	// --------------------------------------------------
	cache_perf_counter u_perf (
		.clock_i      (clock_i),
		.rst_n_i      (rst_n_i),
		.comm_i       (comm_i),
		.metric_sel_i (metric_sel_i),
		.flag_req_i   (flag_req),
		.flag_hit_i   (flag_hit),
		.flag_miss_i  (flag_miss),
		.flag_wb_i    (flag_wb),
		.comm_o       (comm_o)
	);

endmodule

`default_nettype wire

/* hw/cache_perf_counter.sv */
`default_nettype none

module cache_perf_counter (
	input  wire                          clock_i,
	input  wire                          rst_n_i,
	input  wire [31:0]                   comm_i,	// opcode in the low byte
	input  wire cache_ctrl_pkg::metric_t metric_sel_i,
	input  wire                          flag_req_i,
	input  wire                          flag_hit_i,
	input  wire                          flag_miss_i,
	input  wire                          flag_wb_i,
	output logic [31:0]                  comm_o
);

	cache_ctrl_pkg::comm_op_t op;
	logic [31:0] cnt_q [4];	// one counter per metric_t value
	logic [3:0]  evt;
	logic        run_q;

	assign op  = cache_ctrl_pkg::comm_op_t'(comm_i[7:0]);
	assign evt = {flag_wb_i, flag_miss_i, flag_hit_i, flag_req_i};	// metric_t order

	// --------------------------------------------------
	// run control and counting
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q <= 1'b1;	// counting from reset
			for (int i = 0; i < 4; i++)
				cnt_q[i] <= '0;
		end else begin
			if (op == cache_ctrl_pkg::COMM_HOLD)
				run_q <= 1'b0;
			else if (op == cache_ctrl_pkg::COMM_RUN)
				run_q <= 1'b1;
			for (int i = 0; i < 4; i++) begin
				if (op == cache_ctrl_pkg::COMM_CLEAR)
					cnt_q[i] <= '0;	// clear wins over an event
				else if (run_q && evt[i])
					cnt_q[i] <= cnt_q[i] + 32'd1;
			end
		end
	end

	// --------------------------------------------------
	// readout
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i)
			comm_o <= '0;
		else
			comm_o <= cnt_q[metric_sel_i];	// one cycle behind the select
	end

endmodule

`default_nettype wire

/* hw/cache_controller_fa.sv */
`default_nettype none

module cache_controller_fa #(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY),
	localparam int BW_MEM = BW_IDX + cache_cfg_pkg::BW_BLOCK
) (
	input  wire                                    clock_i,
	input  wire                                    rst_n_i,
	input  wire                                    enable_i,	// cache enabled by mem controller

	// core side
	input  wire                                    core_req_i,
	input  wire                                    core_rw_i,	// 1 write, 0 read
	input  wire [cache_cfg_pkg::BW_TAG-1:0]        core_tag_i,
	input  wire [cache_cfg_pkg::BW_BLOCK-1:0]      core_word_i,
	input  wire [cache_cfg_pkg::BW_DATA-1:0]       core_data_i,
	output logic                                   core_done_o,
	output logic                                   core_hit_o,

	// tag memory
	input  wire                                    cam_hit_i,
	input  wire [BW_IDX-1:0]                       cam_addr_i,	// index of the hit
	input  wire [cache_cfg_pkg::BW_TAG-1:0]        cam_tag_i,	// tag of the victim
	output logic                                   cam_wren_o,
	output logic [BW_IDX-1:0]                      cam_addr_o,

	// data memory
	input  wire [cache_cfg_pkg::BW_DATA-1:0]       mem_q_i,
	output logic [BW_MEM-1:0]                      mem_addr_o,
	output logic                                   mem_wren_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]      mem_data_o,

	// buffer data path
	input  wire                                    buffer_read_ready_i,
	input  wire [cache_cfg_pkg::BW_DATA-1:0]       buffer_data_i,
	output logic                                   buffer_read_ack_o,
	input  wire                                    buffer_write_ready_i,
	output logic [cache_cfg_pkg::BW_DATA-1:0]      buffer_data_o,
	output logic                                   buffer_write_ack_o,

	// buffer command path
	input  wire                                    mem_ready_i,
	output logic                                   mem_req_o,
	output logic                                   mem_req_block_o,
	output logic                                   mem_rw_o,	// 1 writeback, 0 fill
	output logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] mem_req_add_o,

	// perf events
	output logic                                   flag_req_o,
	output logic                                   flag_hit_o,
	output logic                                   flag_miss_o,
	output logic                                   flag_wb_o
);

	localparam logic [cache_cfg_pkg::BW_BLOCK-1:0] LAST_WORD = '1;

	cache_ctrl_pkg::ctrl_state_t state_q, state_d;

	logic [BW_IDX-1:0]                   rr_ptr_q;	// round-robin victim, also fill target
	logic [CACHE_BLOCK_CAPACITY-1:0]     dirty_q;
	logic [cache_cfg_pkg::BW_BLOCK-1:0]  wcnt_q;	// word beat inside a block transfer
	logic                                hit_q;	// outcome of the lookup
	logic                                serve;	// LOOKUP or REPLAY
	logic                                hit_write;
	logic                                wr_beat, rd_beat;
	logic                                wb_last, fill_last;

	// --------------------------------------------------
	// beat and hit decode
	// --------------------------------------------------
	assign serve     = (state_q == cache_ctrl_pkg::ST_LOOKUP) ||
	                   (state_q == cache_ctrl_pkg::ST_REPLAY);
	assign hit_write = serve && cam_hit_i && core_rw_i;
	assign wr_beat   = (state_q == cache_ctrl_pkg::ST_WB_DATA) && buffer_write_ready_i;
	assign rd_beat   = (state_q == cache_ctrl_pkg::ST_FILL_DATA) && buffer_read_ready_i;
	assign wb_last   = wr_beat && (wcnt_q == LAST_WORD);
	assign fill_last = rd_beat && (wcnt_q == LAST_WORD);

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			cache_ctrl_pkg::ST_IDLE:
				if (enable_i && core_req_i)
					state_d = cache_ctrl_pkg::ST_LOOKUP;
			cache_ctrl_pkg::ST_LOOKUP:
				if (cam_hit_i)
					state_d = cache_ctrl_pkg::ST_HIT_DONE;
				else if (dirty_q[rr_ptr_q])
					state_d = cache_ctrl_pkg::ST_WB_REQ;	// victim must go out first
				else
					state_d = cache_ctrl_pkg::ST_FILL_REQ;
			cache_ctrl_pkg::ST_HIT_DONE:
				state_d = cache_ctrl_pkg::ST_IDLE;	// always one idle cycle
			cache_ctrl_pkg::ST_WB_REQ:
				if (mem_ready_i)
					state_d = cache_ctrl_pkg::ST_WB_DATA;
			cache_ctrl_pkg::ST_WB_DATA:
				if (wb_last)
					state_d = cache_ctrl_pkg::ST_FILL_REQ;
			cache_ctrl_pkg::ST_FILL_REQ:
				if (mem_ready_i)
					state_d = cache_ctrl_pkg::ST_FILL_DATA;
			cache_ctrl_pkg::ST_FILL_DATA:
				if (fill_last)
					state_d = cache_ctrl_pkg::ST_REPLAY;
			cache_ctrl_pkg::ST_REPLAY:
				state_d = cache_ctrl_pkg::ST_HIT_DONE;
			default:
				state_d = cache_ctrl_pkg::ST_IDLE;
		endcase
	end

	// --------------------------------------------------
	// data memory port
	// --------------------------------------------------
	always_comb begin
		mem_wren_o = 1'b0;
		mem_data_o = core_data_i;
		mem_addr_o = {rr_ptr_q, wcnt_q};	// victim word, word 0 while in WB_REQ
		case (state_q)
			cache_ctrl_pkg::ST_LOOKUP, cache_ctrl_pkg::ST_REPLAY: begin
				mem_addr_o = {cam_addr_i, core_word_i};
				mem_wren_o = hit_write;
			end
			cache_ctrl_pkg::ST_WB_DATA:
				mem_addr_o = {rr_ptr_q, wcnt_q + wr_beat};	// prefetch next word on a beat
			cache_ctrl_pkg::ST_FILL_DATA: begin
				mem_wren_o = rd_beat;
				mem_data_o = buffer_data_i;
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// buffer and core outputs
	// --------------------------------------------------
	assign mem_req_o       = (state_q == cache_ctrl_pkg::ST_WB_REQ) ||
	                         (state_q == cache_ctrl_pkg::ST_FILL_REQ);
	assign mem_req_block_o = mem_req_o;	// only whole-block transfers
	assign mem_rw_o        = (state_q == cache_ctrl_pkg::ST_WB_REQ);
	assign mem_req_add_o   = {(mem_rw_o ? cam_tag_i : core_tag_i),
	                          {cache_cfg_pkg::BW_BLOCK{1'b0}}};	// block base

	assign buffer_write_ack_o = wr_beat;
	assign buffer_read_ack_o  = rd_beat;
	assign buffer_data_o      = mem_q_i;	// word for wcnt_q

	assign cam_addr_o = rr_ptr_q;
	assign cam_wren_o = fill_last;	// new tag lands with the last word

	assign core_done_o = (state_q == cache_ctrl_pkg::ST_HIT_DONE);
	assign core_hit_o  = hit_q;

	assign flag_req_o  = (state_q == cache_ctrl_pkg::ST_IDLE) && enable_i && core_req_i;
	assign flag_hit_o  = (state_q == cache_ctrl_pkg::ST_LOOKUP) && cam_hit_i;
	assign flag_miss_o = (state_q == cache_ctrl_pkg::ST_LOOKUP) && !cam_hit_i;
	assign flag_wb_o   = (state_q == cache_ctrl_pkg::ST_WB_REQ) && mem_ready_i;

	// --------------------------------------------------
	// state, dirty bits, victim pointer
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= cache_ctrl_pkg::ST_IDLE;
			rr_ptr_q <= '0;
			dirty_q  <= '0;
			wcnt_q   <= '0;
			hit_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == cache_ctrl_pkg::ST_LOOKUP)
				hit_q <= cam_hit_i;	// replay keeps the miss
			if (wr_beat || rd_beat)
				wcnt_q <= wcnt_q + 1'b1;	// wraps to 0 after the last beat
			if (fill_last) begin
				dirty_q[rr_ptr_q] <= 1'b0;	// fresh block matches memory
				rr_ptr_q          <= rr_ptr_q + 1'b1;
			end
			if (hit_write)
				dirty_q[cam_addr_i] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/cache_data_mem.sv */
`default_nettype none

// word memory for all blocks, addressed as [block index | word]
module cache_data_mem #(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int DEPTH   = CACHE_BLOCK_CAPACITY * cache_cfg_pkg::WORDS_PER_BLOCK,
	localparam int BW_ADDR = $clog2(DEPTH)
) (
	input  wire                              clock_i,
	input  wire                              wren_i,
	input  wire [BW_ADDR-1:0]                addr_i,	// {index, word}
	input  wire [cache_cfg_pkg::BW_DATA-1:0] data_i,
	output logic [cache_cfg_pkg::BW_DATA-1:0] q_o	// one cycle after addr_i
);

	logic [cache_cfg_pkg::BW_DATA-1:0] mem [DEPTH];

	// single port, behaves like a block RAM with old data on write
	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem[addr_i] <= data_i;
		q_o <= mem[addr_i];	// registered read
	end

endmodule

`default_nettype wire

/* hw/tag_memory_fa.sv */
`default_nettype none

module tag_memory_fa #(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  wire                             clock_i,
	input  wire                             rst_n_i,
	input  wire                             wren_i,	// store tag_i at add_i
	input  wire [cache_cfg_pkg::BW_TAG-1:0] tag_i,	// tag to look up or store
	input  wire [BW_IDX-1:0]                add_i,	// block index for write and tag read
	output logic [BW_IDX-1:0]               add_o,	// index of the matching block
	output logic [cache_cfg_pkg::BW_TAG-1:0] tag_o,	// tag held at add_i
	output logic                            hit_o
);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	logic [cache_cfg_pkg::BW_TAG-1:0] tag_mem [CACHE_BLOCK_CAPACITY];	// one tag per block
	logic [CACHE_BLOCK_CAPACITY-1:0]  valid_q;
	logic [CACHE_BLOCK_CAPACITY-1:0]  match;	// one-hot compare result

	// tags carry no reset, the valid bits guard them
	always_ff @(posedge clock_i) begin
		if (wren_i)
			tag_mem[add_i] <= tag_i;
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;	// empty cache right out of reset
		end else if (wren_i) begin
			valid_q[add_i] <= 1'b1;	// no invalidate path, lines only fill
		end
	end

	// --------------------------------------------------
	// associative lookup
	// --------------------------------------------------
	// every entry compared in the same cycle
	always_comb begin
		add_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			match[i] = valid_q[i] && (tag_mem[i] == tag_i);
			if (match[i])
				add_o = BW_IDX'(i);	// at most one entry can match
		end
	end

	assign hit_o = |match;

	// reverse read, lets the controller rebuild a victim address
	assign tag_o = tag_mem[add_i];

endmodule

`default_nettype wire

/* hw/cache_ctrl_pkg.sv */
`default_nettype none

// encodings used by the controller and the perf counter
package cache_ctrl_pkg;

	// controller FSM states
	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,	// wait for a core request
		ST_LOOKUP    = 3'd1,	// tag compare against all blocks
		ST_HIT_DONE  = 3'd2,	// done pulse to the core
		ST_WB_REQ    = 3'd3,	// ask buffer to take a dirty victim
		ST_WB_DATA   = 3'd4,	// stream victim words out
		ST_FILL_REQ  = 3'd5,	// ask buffer for the missing block
		ST_FILL_DATA = 3'd6,	// stream block words in
		ST_REPLAY    = 3'd7	// serve the request as a hit
	} ctrl_state_t;

	// perf command, lives in comm_i[7:0]
	typedef enum logic [7:0] {
		COMM_NOP   = 8'h00,
		COMM_CLEAR = 8'h01,	// zero all counters
		COMM_HOLD  = 8'h02,	// freeze counting
		COMM_RUN   = 8'h03	// resume counting
	} comm_op_t;

	// which counter shows on comm_o
	typedef enum logic [1:0] {
		MET_REQ  = 2'd0,
		MET_HIT  = 2'd1,
		MET_MISS = 2'd2,
		MET_WB   = 2'd3
	} metric_t;

endpackage

`default_nettype wire

/* hw/cache_cfg_pkg.sv */
`default_nettype none

// address and block geometry shared by every cache block
package cache_cfg_pkg;

	// --------------------------------------------------
	// core word address
	// --------------------------------------------------
	localparam int BW_WORD_ADDR = 16;	// word address from the core
	localparam int BW_DATA      = 32;	// one data word

	// --------------------------------------------------
	// block layout
	// --------------------------------------------------
	// the low address bits pick a word inside the block
	localparam int BW_BLOCK        = 2;
	localparam int WORDS_PER_BLOCK = 1 << BW_BLOCK;	// 4 words per block

	// everything above the word offset is tag in a fully associative cache
	localparam int BW_TAG = BW_WORD_ADDR - BW_BLOCK;	// 14 bits

endpackage

`default_nettype wire
